// File: hdl/usiPkg.sv
//------------------------------------------------
// USI register bus shared definitions
// Bus widths, block map, host opcodes and the
// register offsets of the peripherals
//------------------------------------------------
`default_nettype none

package usiPkg;

	// Bus widths
	localparam int USI_DATA_BITS = 32;
	localparam int USI_ADRS_BITS = 16;

	typedef logic [USI_DATA_BITS-1:0] usiDataT;
	typedef logic [USI_ADRS_BITS-1:0] usiAdrsT;

	// Block map, upper address byte
	typedef enum logic [7:0] {
		BLK_GPIO = 8'h01,
		BLK_PWM  = 8'h02
	} blockIdE;

	// Host command opcodes
	typedef enum logic [7:0] {
		CMD_WRITE = 8'h57,
		CMD_READ  = 8'h52
	} cmdOpE;

	// Reply bytes to the host
	localparam logic [7:0] ACK_BYTE = 8'h4B;
	localparam logic [7:0] ERR_BYTE = 8'h45;

	// Register offsets, lower address byte
	localparam logic [7:0] GPIO_LED_REG = 8'h00;
	localparam logic [7:0] GPIO_DIV_REG = 8'h04;
	localparam logic [7:0] PWM_DUTY_REG = 8'h00;

endpackage

`default_nettype wire

// File: hdl/uartPhy.sv
//------------------------------------------------
// Serial line PHY, 8N1 framing
// Receiver with mid-bit sampling and a
// ten-bit frame transmitter
//------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module uartPhy #(
	parameter int pClksPerBit = 16
)(
	input  logic       sysClk,
	input  logic       rstN,
	input  logic       rx,
	output logic       tx,
	output logic [7:0] rxByte,
	output logic       rxValid,
	input  logic [7:0] txByte,
	input  logic       txStart,
	output logic       txReady
);

localparam int CNT_BITS = $clog2(pClksPerBit + 1);
localparam logic [CNT_BITS-1:0] FULL_CNT = CNT_BITS'(pClksPerBit - 1);
localparam logic [CNT_BITS-1:0] HALF_CNT = CNT_BITS'(pClksPerBit / 2 - 1);

typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rxStateE;
typedef enum logic {TX_IDLE, TX_SHIFT} txStateE;

//------------------------------------------------
// Receiver
//------------------------------------------------
rxStateE               rxState;
logic [1:0]            rxSync;
logic [CNT_BITS-1:0]   rxClkCnt;
logic [2:0]            rxBitCnt;
logic [7:0]            rxShift;

// Shift register holds the byte, LSB arrives first
assign rxByte = rxShift;

always_ff @(posedge sysClk)
begin
	// Two-stage synchronizer, idle high
	if (!rstN)
		rxSync <= 2'b11;
	else
		rxSync <= {rxSync[0], rx};
end

always_ff @(posedge sysClk)
begin
	if (!rstN)
	begin
		rxState  <= RX_IDLE;
		rxClkCnt <= '0;
		rxBitCnt <= '0;
		rxValid  <= 1'b0;
	end
	else
	begin
		rxValid <= 1'b0;
		case (rxState)
			RX_IDLE:
			begin
				rxClkCnt <= '0;
				// Falling edge may be a start bit
				if (!rxSync[1])
					rxState <= RX_START;
			end
			RX_START:
			begin
				if (rxClkCnt == HALF_CNT)
				begin
					rxClkCnt <= '0;
					rxBitCnt <= '0;
					// Glitch check at mid start bit
					rxState  <= rxSync[1] ? RX_IDLE : RX_DATA;
				end
				else
					rxClkCnt <= rxClkCnt + 1'b1;
			end
			RX_DATA:
			begin
				if (rxClkCnt == FULL_CNT)
				begin
					rxClkCnt <= '0;
					rxShift  <= {rxSync[1], rxShift[7:1]};
					if (rxBitCnt == 3'd7)
						rxState <= RX_STOP;
					else
						rxBitCnt <= rxBitCnt + 1'b1;
				end
				else
					rxClkCnt <= rxClkCnt + 1'b1;
			end
			default:
			begin
				// Mid stop bit, byte is complete
				if (rxClkCnt == FULL_CNT)
				begin
					rxValid <= 1'b1;
					rxState <= RX_IDLE;
				end
				else
					rxClkCnt <= rxClkCnt + 1'b1;
			end
		endcase
	end
end

//------------------------------------------------
// Transmitter
//------------------------------------------------
txStateE               txState;
logic [CNT_BITS-1:0]   txClkCnt;
logic [3:0]            txBitCnt;
logic [9:0]            txShift;

assign tx      = txShift[0];
assign txReady = (txState == TX_IDLE);

always_ff @(posedge sysClk)
begin
	if (!rstN)
	begin
		txState  <= TX_IDLE;
		txClkCnt <= '0;
		txBitCnt <= '0;
		txShift  <= '1;
	end
	else if (txState == TX_IDLE)
	begin
		txClkCnt <= '0;
		txBitCnt <= '0;
		if (txStart)
		begin
			// Stop, data LSB first, start
			txShift <= {1'b1, txByte, 1'b0};
			txState <= TX_SHIFT;
		end
	end
	else if (txClkCnt == FULL_CNT)
	begin
		txClkCnt <= '0;
		// Ones refill behind, line stays idle high
		txShift  <= {1'b1, txShift[9:1]};
		if (txBitCnt == 4'd9)
			txState <= TX_IDLE;
		else
			txBitCnt <= txBitCnt + 1'b1;
	end
	else
		txClkCnt <= txClkCnt + 1'b1;
end

endmodule

`default_nettype wire

// File: hdl/usiCommandMaster.sv
//------------------------------------------------
// USI command master
// Parses host frames from the serial PHY, runs
// one bus access per frame and sends the reply
//------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module usiCommandMaster (
	input  logic           sysClk,
	input  logic           rstN,
	input  logic [7:0]     rxByte,
	input  logic           rxValid,
	output logic [7:0]     txByte,
	output logic           txStart,
	input  logic           txReady,
	output usiPkg::usiAdrsT usiAdrs,
	output usiPkg::usiDataT usiWd,
	output logic           usiWCke,
	output logic           usiRCke,
	input  usiPkg::usiDataT usiRd,
	input  logic           usiVd
);

import usiPkg::*;

typedef enum logic [2:0] {
	S_OPCODE, S_ADRS, S_DATA, S_WAIT, S_REPLY, S_DRAIN
} frameStateE;

frameStateE state;
cmdOpE      cmdOp;
logic [1:0] byteCnt;
// Reply bytes left minus one
logic [1:0] replyCnt;
usiDataT    replyData;

always_ff @(posedge sysClk)
begin
	if (!rstN)
	begin
		state    <= S_OPCODE;
		byteCnt  <= '0;
		replyCnt <= '0;
		txStart  <= 1'b0;
		usiWCke  <= 1'b0;
		usiRCke  <= 1'b0;
	end
	else
	begin
		// Strobes are single-cycle pulses
		txStart <= 1'b0;
		usiWCke <= 1'b0;
		usiRCke <= 1'b0;
		case (state)
			S_OPCODE:
			begin
				byteCnt <= '0;
				if (rxValid)
				begin
					cmdOp <= cmdOpE'(rxByte);
					if (rxByte == CMD_WRITE || rxByte == CMD_READ)
						state <= S_ADRS;
					else
					begin
						// Unknown opcode, reject at once
						replyData <= {ERR_BYTE, 24'h0};
						replyCnt  <= 2'd0;
						state     <= S_REPLY;
					end
				end
			end
			S_ADRS:
			begin
				if (rxValid)
				begin
					usiAdrs <= {usiAdrs[USI_ADRS_BITS-9:0], rxByte};
					byteCnt <= byteCnt + 1'b1;
					if (byteCnt == 2'd1)
					begin
						byteCnt <= '0;
						if (cmdOp == CMD_READ)
						begin
							usiRCke <= 1'b1;
							state   <= S_WAIT;
						end
						else
							state <= S_DATA;
					end
				end
			end
			S_DATA:
			begin
				if (rxValid)
				begin
					usiWd   <= {usiWd[USI_DATA_BITS-9:0], rxByte};
					byteCnt <= byteCnt + 1'b1;
					// Last data byte lands with the write strobe
					if (byteCnt == 2'd3)
					begin
						usiWCke   <= 1'b1;
						replyData <= {ACK_BYTE, 24'h0};
						replyCnt  <= 2'd0;
						state     <= S_REPLY;
					end
				end
			end
			S_WAIT:
			begin
				if (usiVd)
				begin
					replyData <= usiRd;
					replyCnt  <= 2'd3;
					state     <= S_REPLY;
				end
			end
			S_REPLY:
			begin
				// txReady lags txStart by one cycle
				if (txReady && !txStart)
				begin
					txStart   <= 1'b1;
					txByte    <= replyData[USI_DATA_BITS-1 -: 8];
					replyData <= {replyData[USI_DATA_BITS-9:0], 8'h00};
					replyCnt  <= replyCnt - 1'b1;
					if (replyCnt == 2'd0)
						state <= S_DRAIN;
				end
			end
			default:
			begin
				// Hold off new frames until the last byte is out
				if (txReady && !txStart)
					state <= S_OPCODE;
			end
		endcase
	end
end

endmodule

`default_nettype wire

// File: hdl/usiBus.sv
//------------------------------------------------
// USI bus block decode
// Routes master strobes by the upper address
// byte and registers the returned read data
//------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module usiBus (
	input  logic            sysClk,
	input  logic            rstN,
	input  usiPkg::usiAdrsT usiAdrs,
	input  usiPkg::usiDataT usiWd,
	input  logic            usiWCke,
	input  logic            usiRCke,
	output usiPkg::usiDataT usiRd,
	output logic            usiVd,
	output logic [7:0]      regAdrs,
	output usiPkg::usiDataT regWd,
	output logic            gpioWCke,
	output logic            gpioRCke,
	output logic            pwmWCke,
	output logic            pwmRCke,
	input  usiPkg::usiDataT gpioRd,
	input  logic            gpioVd,
	input  usiPkg::usiDataT pwmRd,
	input  logic            pwmVd
);

import usiPkg::*;

blockIdE blkId;
logic    gpioSel;
logic    pwmSel;
// Read to an unmapped block in flight
logic    unmappedRd;

//------------------------------------------------
// Block decode and strobe fan-out
//------------------------------------------------
assign blkId   = blockIdE'(usiAdrs[USI_ADRS_BITS-1 -: 8]);
assign gpioSel = (blkId == BLK_GPIO);
assign pwmSel  = (blkId == BLK_PWM);

assign gpioWCke = usiWCke & gpioSel;
assign gpioRCke = usiRCke & gpioSel;
assign pwmWCke  = usiWCke & pwmSel;
assign pwmRCke  = usiRCke & pwmSel;

// Register offset and data shared by all slaves
assign regAdrs = usiAdrs[7:0];
assign regWd   = usiWd;

//------------------------------------------------
// Read return, one register stage
//------------------------------------------------
always_ff @(posedge sysClk)
begin
	if (!rstN)
	begin
		unmappedRd <= 1'b0;
		usiVd      <= 1'b0;
	end
	else
	begin
		// Stands in for the missing slave's vd
		unmappedRd <= usiRCke & ~gpioSel & ~pwmSel;
		usiVd      <= gpioVd | pwmVd | unmappedRd;
	end
end

always_ff @(posedge sysClk)
begin
	if (gpioVd)
		usiRd <= gpioRd;
	else if (pwmVd)
		usiRd <= pwmRd;
	else
		usiRd <= '0;
end

endmodule

`default_nettype wire

// File: hdl/gpioBlock.sv
//------------------------------------------------
// GPIO block
// Status LED register and a blink clock with a
// programmable divisor
//------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module gpioBlock #(
	parameter int pDivBits = 16
)(
	input  logic            sysClk,
	input  logic            rstN,
	input  logic [7:0]      adrs,
	input  usiPkg::usiDataT wd,
	input  logic            wCke,
	input  logic            rCke,
	output usiPkg::usiDataT rd,
	output logic            vd,
	output logic [1:0]      ledEdge,
	output logic            ledClk
);

import usiPkg::*;

logic [1:0]          ledReg;
logic [pDivBits-1:0] divReg;
logic [pDivBits-1:0] divCnt;

assign ledEdge = ledReg;

// Register writes
always_ff @(posedge sysClk)
begin
	if (!rstN)
	begin
		ledReg <= '0;
		divReg <= '0;
	end
	else if (wCke)
	begin
		if (adrs == GPIO_LED_REG)
			ledReg <= wd[1:0];
		if (adrs == GPIO_DIV_REG)
			divReg <= wd[pDivBits-1:0];
	end
end

//------------------------------------------------
// Blink clock, half period of divisor plus one
//------------------------------------------------
always_ff @(posedge sysClk)
begin
	if (!rstN || divReg == '0)
	begin
		divCnt <= '0;
		ledClk <= 1'b0;
	end
	else if (divCnt >= divReg)
	begin
		// Also catches a divisor lowered mid-count
		divCnt <= '0;
		ledClk <= ~ledClk;
	end
	else
		divCnt <= divCnt + 1'b1;
end

// Read back, one cycle after rCke
always_ff @(posedge sysClk)
begin
	if (!rstN)
		vd <= 1'b0;
	else
		vd <= rCke;
end

always_ff @(posedge sysClk)
begin
	case (adrs)
		GPIO_LED_REG: rd <= usiDataT'(ledReg);
		GPIO_DIV_REG: rd <= usiDataT'(divReg);
		default:      rd <= '0;
	endcase
end

endmodule

`default_nettype wire

// File: hdl/pwmBlock.sv
//------------------------------------------------
// PWM block for the display backlight
// 8-bit duty over a 256-cycle period
//------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module pwmBlock (
	input  logic            sysClk,
	input  logic            rstN,
	input  logic [7:0]      adrs,
	input  usiPkg::usiDataT wd,
	input  logic            wCke,
	input  logic            rCke,
	output usiPkg::usiDataT rd,
	output logic            vd,
	output logic            backLight
);

import usiPkg::*;

logic [7:0] dutyReg;
// Free-running, wraps every 256 cycles
logic [7:0] pwmCnt;

always_ff @(posedge sysClk)
begin
	if (!rstN)
	begin
		dutyReg   <= '0;
		pwmCnt    <= '0;
		backLight <= 1'b0;
		vd        <= 1'b0;
	end
	else
	begin
		if (wCke && adrs == PWM_DUTY_REG)
			dutyReg <= wd[7:0];
		pwmCnt    <= pwmCnt + 1'b1;
		// Duty of zero never goes high
		backLight <= (pwmCnt < dutyReg);
		vd        <= rCke;
	end
end

// Read data, valid with vd
always_ff @(posedge sysClk)
begin
	if (adrs == PWM_DUTY_REG)
		rd <= usiDataT'(dutyReg);
	else
		rd <= '0;
end

endmodule

`default_nettype wire

// File: hdl/processor.sv
//------------------------------------------------
// Display SoC control plane
// Host serial commands drive the USI bus with
// the GPIO and backlight PWM peripherals
//------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module processor #(
	parameter int pClksPerBit = 16
)(
	input  logic       sysClk,
	input  logic       rstN,
	input  logic       uartRx,
	output logic       uartTx,
	output logic [1:0] ledEdge,
	output logic       ledClk,
	output logic       backLight
);

// PHY to master
logic [7:0] rxByte;
logic       rxValid;
logic [7:0] txByte;
logic       txStart;
logic       txReady;

// Master side of the bus
usiPkg::usiAdrsT usiAdrs;
usiPkg::usiDataT usiWd;
usiPkg::usiDataT usiRd;
logic            usiWCke;
logic            usiRCke;
logic            usiVd;

// Slave side of the bus
logic [7:0]      regAdrs;
usiPkg::usiDataT regWd;
usiPkg::usiDataT gpioRd;
usiPkg::usiDataT pwmRd;
logic            gpioWCke;
logic            gpioRCke;
logic            gpioVd;
logic            pwmWCke;
logic            pwmRCke;
logic            pwmVd;

//------------------------------------------------
// Host link
//------------------------------------------------
uartPhy #(
	.pClksPerBit (pClksPerBit)
) uartPhyInst (
	.sysClk  (sysClk),
	.rstN    (rstN),
	.rx      (uartRx),
	.tx      (uartTx),
	.rxByte  (rxByte),
	.rxValid (rxValid),
	.txByte  (txByte),
	.txStart (txStart),
	.txReady (txReady)
);

usiCommandMaster masterInst (
	.sysClk  (sysClk),
	.rstN    (rstN),
	.rxByte  (rxByte),
	.rxValid (rxValid),
	.txByte  (txByte),
	.txStart (txStart),
	.txReady (txReady),
	.usiAdrs (usiAdrs),
	.usiWd   (usiWd),
	.usiWCke (usiWCke),
	.usiRCke (usiRCke),
	.usiRd   (usiRd),
	.usiVd   (usiVd)
);

//------------------------------------------------
// USI bus and peripherals
//------------------------------------------------
usiBus busInst (
	.sysClk   (sysClk),
	.rstN     (rstN),
	.usiAdrs  (usiAdrs),
	.usiWd    (usiWd),
	.usiWCke  (usiWCke),
	.usiRCke  (usiRCke),
	.usiRd    (usiRd),
	.usiVd    (usiVd),
	.regAdrs  (regAdrs),
	.regWd    (regWd),
	.gpioWCke (gpioWCke),
	.gpioRCke (gpioRCke),
	.pwmWCke  (pwmWCke),
	.pwmRCke  (pwmRCke),
	.gpioRd   (gpioRd),
	.gpioVd   (gpioVd),
	.pwmRd    (pwmRd),
	.pwmVd    (pwmVd)
);

gpioBlock #(
	.pDivBits (16)
) gpioInst (
	.sysClk  (sysClk),
	.rstN    (rstN),
	.adrs    (regAdrs),
	.wd      (regWd),
	.wCke    (gpioWCke),
	.rCke    (gpioRCke),
	.rd      (gpioRd),
	.vd      (gpioVd),
	.ledEdge (ledEdge),
	.ledClk  (ledClk)
);

pwmBlock pwmInst (
	.sysClk    (sysClk),
	.rstN      (rstN),
	.adrs      (regAdrs),
	.wd        (regWd),
	.wCke      (pwmWCke),
	.rCke      (pwmRCke),
	.rd        (pwmRd),
	.vd        (pwmVd),
	.backLight (backLight)
);

endmodule

`default_nettype wire

// File: bench/processorChecker.sv
//------------------------------------------------
// Processor testbench checker
// Decodes replies on uartTx, watches the LED and
// backlight pins and counts mismatches
//------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module processorChecker #(
	parameter int pClksPerBit = 16
)(
	input logic       sysClk,
	input logic       rstN,
	input logic       uartTx,
	input logic [1:0] ledEdge,
	input logic       ledClk,
	input logic       backLight
);

// Reply bytes still owed by the DUT, oldest first
logic [7:0] expQ[$];
int         errorCount = 0;

task automatic compareValue(input string what, input int got, input int exp);
	if (got != exp)
	begin
		$display("FAILED %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
		errorCount++;
	end
endtask

task automatic expectByte(input logic [7:0] b);
	expQ.push_back(b);
endtask

//------------------------------------------------
// Serial reply decoder
//------------------------------------------------
// Entered on the first low sample of a start bit
task automatic sampleTxByte(output logic [7:0] data, output logic framed);
	int i;
	repeat (pClksPerBit / 2 - 1) @(negedge sysClk);
	framed = !uartTx;
	for (i = 0; i < 8; i++)
	begin
		repeat (pClksPerBit) @(negedge sysClk);
		data[i] = uartTx;
	end
	// Mid stop bit
	repeat (pClksPerBit) @(negedge sysClk);
	framed = framed && uartTx;
endtask

initial
begin : replyDecoder
	logic [7:0] got;
	logic       framed;
	forever
	begin
		@(negedge sysClk);
		if (rstN && !uartTx)
		begin
			sampleTxByte(got, framed);
			if (!framed)
			begin
				$display("Framing error on uartTx near %0t ns", $time);
				errorCount++;
			end
			else if (expQ.size() == 0)
			begin
				$display("FAILED %0t ns: unexpected reply byte 0x%02h", $time, got);
				errorCount++;
			end
			else
				compareValue("reply byte", got, expQ.pop_front());
		end
	end
end

// Blocks until every owed byte is decoded
task automatic waitReplies();
	int limit;
	int n;
	limit = (expQ.size() + 2) * 12 * pClksPerBit + 200;
	n = 0;
	while (expQ.size() != 0 && n < limit)
	begin
		@(negedge sysClk);
		n++;
	end
	if (expQ.size() != 0)
	begin
		$display("Timeout: %0d reply bytes never arrived on uartTx", expQ.size());
		errorCount++;
		expQ.delete();
	end
endtask

//------------------------------------------------
// Pin checks
//------------------------------------------------
task automatic checkResetPins();
	@(negedge sysClk);
	compareValue("ledEdge after reset", ledEdge, 0);
	compareValue("ledClk after reset", ledClk, 0);
	compareValue("backLight after reset", backLight, 0);
	compareValue("uartTx after reset", uartTx, 1);
endtask

task automatic checkPins(input logic [1:0] expLed, input logic expClk);
	@(negedge sysClk);
	compareValue("ledEdge", ledEdge, expLed);
	compareValue("ledClk", ledClk, expClk);
endtask

// One full PWM period
task automatic measureBacklight(input int duty);
	int highs;
	int n;
	highs = 0;
	for (n = 0; n < 256; n++)
	begin
		@(negedge sysClk);
		if (backLight)
			highs++;
	end
	compareValue("backLight high cycles", highs, duty);
endtask

// First edge only syncs, then two spacings are timed
task automatic measureBlink(input int div);
	logic lastClk;
	int   gap;
	int   limit;
	int   edgeNum;
	limit = 2 * (div + 1) + 16;
	@(negedge sysClk);
	for (edgeNum = 0; edgeNum < 3; edgeNum++)
	begin
		lastClk = ledClk;
		gap = 0;
		while (ledClk == lastClk && gap < limit)
		begin
			@(negedge sysClk);
			gap++;
		end
		if (ledClk == lastClk)
		begin
			$display("Timeout: ledClk did not toggle within %0d cycles", limit);
			errorCount++;
			return;
		end
		if (edgeNum > 0)
			compareValue("ledClk edge spacing", gap, div + 1);
	end
endtask

endmodule

`default_nettype wire

// File: bench/usiBus_sva.sv
//------------------------------------------------
// USI bus assertions
// Strobe exclusivity, reset quiet and the
// two-cycle read return
//------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module usiBusSva (
	input logic sysClk,
	input logic rstN,
	input logic usiWCke,
	input logic usiRCke,
	input logic usiVd,
	input logic gpioWCke,
	input logic gpioRCke,
	input logic pwmWCke,
	input logic pwmRCke
);

// Number of assertion failures so far
int failCount = 0;

// One access at a time from the master
strobeExclusive: assert property (@(posedge sysClk) disable iff (!rstN)
	!(usiWCke && usiRCke))
	else
	begin
		$error("usiWCke and usiRCke high together");
		failCount++;
	end

// Read data returns two cycles after the strobe
readLatency: assert property (@(posedge sysClk) disable iff (!rstN)
	$past(usiRCke, 2) |-> usiVd)
	else
	begin
		$error("usiVd missing two cycles after usiRCke");
		failCount++;
	end

noStrayValid: assert property (@(posedge sysClk) disable iff (!rstN)
	usiVd |-> $past(usiRCke, 2))
	else
	begin
		$error("usiVd without usiRCke two cycles before");
		failCount++;
	end

// Only checked once reset has been held for a full cycle
resetQuiet: assert property (@(posedge sysClk)
	(!rstN && $past(!rstN)) |->
	!(usiWCke || usiRCke || gpioWCke || gpioRCke || pwmWCke || pwmRCke))
	else
	begin
		$error("bus strobe high during reset");
		failCount++;
	end

endmodule

bind usiBus usiBusSva usiBusSvaInst (
	.sysClk   (sysClk),
	.rstN     (rstN),
	.usiWCke  (usiWCke),
	.usiRCke  (usiRCke),
	.usiVd    (usiVd),
	.gpioWCke (gpioWCke),
	.gpioRCke (gpioRCke),
	.pwmWCke  (pwmWCke),
	.pwmRCke  (pwmRCke)
);

`default_nettype wire

// File: bench/processorTb.sv
//------------------------------------------------
// Processor testbench
// Host-side serial stimulus, register reference
// model and per-test reporting
//------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module processorTb;

import usiPkg::*;

localparam int CLKS_PER_BIT    = 16;
localparam int WATCHDOG_CYCLES = 400000;

logic       sysClk;
logic       rstN;
logic       uartRx;
logic       uartTx;
logic [1:0] ledEdge;
logic       ledClk;
logic       backLight;

// Reference register file
logic [1:0]  refLed;
logic [15:0] refDiv;
logic [7:0]  refDuty;

int testCount;
int failedTests;

processor #(
	.pClksPerBit (CLKS_PER_BIT)
) processor_inst (
	.sysClk    (sysClk),
	.rstN      (rstN),
	.uartRx    (uartRx),
	.uartTx    (uartTx),
	.ledEdge   (ledEdge),
	.ledClk    (ledClk),
	.backLight (backLight)
);

processorChecker #(
	.pClksPerBit (CLKS_PER_BIT)
) checkerInst (
	.sysClk    (sysClk),
	.rstN      (rstN),
	.uartTx    (uartTx),
	.ledEdge   (ledEdge),
	.ledClk    (ledClk),
	.backLight (backLight)
);

// 8 ns clock
initial
begin
	sysClk = 1'b0;
	forever #4 sysClk = ~sysClk;
end

initial
begin : watchdog
	int n;
	for (n = 0; n < WATCHDOG_CYCLES; n++)
		@(posedge sysClk);
	$display("Simulation watchdog expired after %0d cycles", WATCHDOG_CYCLES);
	$display("Finished with errors");
	$finish;
end

//------------------------------------------------
// Reference model
//------------------------------------------------
// Returns the reply length with the bytes right-aligned in reply
function automatic int refReply(input logic [7:0] op, input logic [15:0] adrs,
	input logic [31:0] data, output logic [31:0] reply);
	logic [7:0] blk;
	logic [7:0] offs;
	blk   = adrs[15:8];
	offs  = adrs[7:0];
	reply = '0;
	if (op == CMD_WRITE)
	begin
		// Unmapped blocks and offsets drop the data
		if (blk == BLK_GPIO && offs == GPIO_LED_REG)
			refLed = data[1:0];
		if (blk == BLK_GPIO && offs == GPIO_DIV_REG)
			refDiv = data[15:0];
		if (blk == BLK_PWM && offs == PWM_DUTY_REG)
			refDuty = data[7:0];
		reply[7:0] = ACK_BYTE;
		return 1;
	end
	else if (op == CMD_READ)
	begin
		if (blk == BLK_GPIO && offs == GPIO_LED_REG)
			reply = {30'h0, refLed};
		else if (blk == BLK_GPIO && offs == GPIO_DIV_REG)
			reply = {16'h0, refDiv};
		else if (blk == BLK_PWM && offs == PWM_DUTY_REG)
			reply = {24'h0, refDuty};
		return 4;
	end
	reply[7:0] = ERR_BYTE;
	return 1;
endfunction

//------------------------------------------------
// Host stimulus
//------------------------------------------------
// Start bit, LSB first data, stop bit
task automatic sendByte(input logic [7:0] b);
	logic [9:0] frame;
	int         i;
	frame = {1'b1, b, 1'b0};
	for (i = 0; i < 10; i++)
	begin
		@(posedge sysClk);
		uartRx <= frame[i];
		repeat (CLKS_PER_BIT - 1) @(posedge sysClk);
	end
endtask

task automatic runCommand(input logic [7:0] op, input logic [15:0] adrs,
	input logic [31:0] data);
	logic [31:0] reply;
	int          count;
	int          i;
	count = refReply(op, adrs, data, reply);
	for (i = count - 1; i >= 0; i--)
		checkerInst.expectByte(reply[8*i +: 8]);
	sendByte(op);
	// Unknown opcodes are answered after one byte
	if (op == CMD_WRITE || op == CMD_READ)
	begin
		sendByte(adrs[15:8]);
		sendByte(adrs[7:0]);
	end
	if (op == CMD_WRITE)
		for (i = 3; i >= 0; i--)
			sendByte(data[8*i +: 8]);
	checkerInst.waitReplies();
endtask

task automatic finishTest(input string name, input int errorsBefore);
	int errs;
	testCount++;
	errs = checkerInst.errorCount - errorsBefore;
	if (errs == 0)
		$display("Test %0d %s: passed", testCount, name);
	else
	begin
		failedTests++;
		$display("Test %0d %s: failed with %0d errors", testCount, name, errs);
	end
endtask

//------------------------------------------------
// Test sequence
//------------------------------------------------
initial
begin : testSequence
	int          errStart;
	int          n;
	logic [31:0] data;
	logic [7:0]  op;
	rstN        = 1'b0;
	uartRx      = 1'b1;
	refLed      = '0;
	refDiv      = '0;
	refDuty     = '0;
	testCount   = 0;
	failedTests = 0;
	void'($urandom(60));
	repeat (16) @(posedge sysClk);
	rstN <= 1'b1;
	@(posedge sysClk);

	errStart = checkerInst.errorCount;
	checkerInst.checkResetPins();
	finishTest("reset state", errStart);

	// LED register write and read back
	errStart = checkerInst.errorCount;
	runCommand(CMD_WRITE, {BLK_GPIO, GPIO_LED_REG}, 32'hDEAD_BEE2);
	checkerInst.checkPins(refLed, 1'b0);
	runCommand(CMD_READ, {BLK_GPIO, GPIO_LED_REG}, '0);
	data = $urandom;
	runCommand(CMD_WRITE, {BLK_GPIO, GPIO_LED_REG}, data);
	checkerInst.checkPins(refLed, 1'b0);
	runCommand(CMD_READ, {BLK_GPIO, GPIO_LED_REG}, '0);
	finishTest("gpio led register", errStart);

	// Random duties with one full period measured each
	errStart = checkerInst.errorCount;
	for (n = 0; n < 4; n++)
	begin
		data = $urandom;
		runCommand(CMD_WRITE, {BLK_PWM, PWM_DUTY_REG}, data);
		runCommand(CMD_READ, {BLK_PWM, PWM_DUTY_REG}, '0);
		checkerInst.measureBacklight(refDuty);
	end
	finishTest("pwm duty", errStart);

	// Unmapped block accesses leave the pins unchanged
	errStart = checkerInst.errorCount;
	runCommand(CMD_READ, 16'h0700, '0);
	runCommand(CMD_READ, 16'hA504, '0);
	runCommand(CMD_WRITE, 16'hA500, $urandom);
	checkerInst.checkPins(refLed, 1'b0);
	checkerInst.measureBacklight(refDuty);
	runCommand(CMD_READ, {BLK_GPIO, GPIO_LED_REG}, '0);
	runCommand(CMD_READ, {BLK_PWM, PWM_DUTY_REG}, '0);
	finishTest("unmapped block", errStart);

	// Bad opcodes followed by a normal read
	errStart = checkerInst.errorCount;
	runCommand(8'h3C, 16'h0100, '0);
	data = $urandom;
	op = data[7:0];
	if (op == CMD_WRITE || op == CMD_READ)
		op = op ^ 8'h80;
	runCommand(op, 16'h0100, '0);
	runCommand(CMD_READ, {BLK_PWM, PWM_DUTY_REG}, '0);
	finishTest("unknown opcode", errStart);

	// Small blink divisors so edges come quickly
	errStart = checkerInst.errorCount;
	for (n = 0; n < 2; n++)
	begin
		data = 32'(5 + $urandom % 40);
		runCommand(CMD_WRITE, {BLK_GPIO, GPIO_DIV_REG}, data);
		runCommand(CMD_READ, {BLK_GPIO, GPIO_DIV_REG}, '0);
		checkerInst.measureBlink(refDiv);
	end
	finishTest("blink divisor", errStart);

	$display("Tests run %0d, tests failed %0d, errors %0d, assertion failures %0d",
		testCount, failedTests, checkerInst.errorCount,
		processor_inst.busInst.usiBusSvaInst.failCount);
	if (checkerInst.errorCount == 0 && failedTests == 0 &&
		processor_inst.busInst.usiBusSvaInst.failCount == 0)
		$display("Finished with no errors");
	else
		$display("Finished with errors");
	$finish;
end

endmodule

`default_nettype wire

// File: project.f
hdl/usiPkg.sv
hdl/uartPhy.sv
hdl/usiCommandMaster.sv
hdl/usiBus.sv
hdl/gpioBlock.sv
hdl/pwmBlock.sv
hdl/processor.sv
bench/processorChecker.sv
bench/usiBus_sva.sv
bench/processorTb.sv

// File: Makefile
# Verilator build and run of the processor testbench
TOP = processorTb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f

# Pass or fail comes from the printed result line
run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
